// ==== include/clint_config.svh ====
`ifndef CLINT_CONFIG_SVH
`define CLINT_CONFIG_SVH

`define CLINT_XLEN 32

// standard machine csr addresses
`define CLINT_CSR_MSTATUS  12'h300
`define CLINT_CSR_MISA     12'h301
`define CLINT_CSR_MIE      12'h304
`define CLINT_CSR_MTVEC    12'h305
`define CLINT_CSR_MSCRATCH 12'h340
`define CLINT_CSR_MEPC     12'h341
`define CLINT_CSR_MCAUSE   12'h342
`define CLINT_CSR_MIP      12'h344
`define CLINT_CSR_MHARTID  12'hF14

// mstatus bit positions
`define CLINT_MSTATUS_MIE  3
`define CLINT_MSTATUS_MPIE 7

// mcause values, bit 31 flags an interrupt
`define CLINT_CAUSE_ECALL  32'd11
`define CLINT_CAUSE_EBREAK 32'd3
`define CLINT_CAUSE_MTIMER 32'h8000_0007

// mxl = 1 (32 bit), only the I extension
`define CLINT_MISA_VALUE    32'h4000_0100
`define CLINT_MHARTID_VALUE 32'h0000_0000

`endif

// ==== src/clint_pkg.sv ====
package clint_pkg;

    // request opcodes from the decoder
    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,
        OP_CSRRW  = 3'd1,
        OP_CSRRS  = 3'd2,
        OP_CSRRC  = 3'd3,
        OP_ECALL  = 3'd4,
        OP_EBREAK = 3'd5,
        OP_MRET   = 3'd6
    } csr_op_e;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_CSR    = 3'd1,  // csr read-modify-write
        ST_CAUSE  = 3'd2,  // trap: mcause
        ST_EPC    = 3'd3,  // trap: mepc
        ST_STATUS = 3'd4,  // trap or mret: mstatus
        ST_JUMP   = 3'd5
    } clint_state_e;

endpackage

// ==== src/csr_regfile.sv ====
`timescale 1ns/1ps
`include "clint_config.svh"

module csr_regfile (
    input  logic                   clk,
    input  logic                   rst_n,

    // write port
    input  logic                   csr_we_i,
    input  logic [11:0]            csr_waddr_i,
    input  logic [`CLINT_XLEN-1:0] csr_wdata_i,

    // read port
    input  logic [11:0]            csr_raddr_i,
    output logic [`CLINT_XLEN-1:0] csr_rdata_o,

    // direct views for the sequencer
    output logic [`CLINT_XLEN-1:0] mstatus_o,
    output logic [`CLINT_XLEN-1:0] mepc_o,
    output logic [`CLINT_XLEN-1:0] mtvec_o
);

    logic [`CLINT_XLEN-1:0] mstatus_q;
    logic [`CLINT_XLEN-1:0] mie_q;
    logic [`CLINT_XLEN-1:0] mtvec_q;
    logic [`CLINT_XLEN-1:0] mscratch_q;
    logic [`CLINT_XLEN-1:0] mepc_q;
    logic [`CLINT_XLEN-1:0] mcause_q;
    logic [`CLINT_XLEN-1:0] mip_q;

    assign mstatus_o = mstatus_q;
    assign mepc_o    = mepc_q;
    assign mtvec_o   = mtvec_q;

    // combinational read
    always_comb begin
        case (csr_raddr_i)
            `CLINT_CSR_MSTATUS:  csr_rdata_o = mstatus_q;
            `CLINT_CSR_MISA:     csr_rdata_o = `CLINT_MISA_VALUE;
            `CLINT_CSR_MIE:      csr_rdata_o = mie_q;
            `CLINT_CSR_MTVEC:    csr_rdata_o = mtvec_q;
            `CLINT_CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            `CLINT_CSR_MEPC:     csr_rdata_o = mepc_q;
            `CLINT_CSR_MCAUSE:   csr_rdata_o = mcause_q;
            `CLINT_CSR_MIP:      csr_rdata_o = mip_q;
            `CLINT_CSR_MHARTID:  csr_rdata_o = `CLINT_MHARTID_VALUE;
            default:             csr_rdata_o = '0;  // unmapped
        endcase
    end

    // one write per cycle, visible to a read on the next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q  <= '0;  // mie = 0, interrupts off
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mip_q      <= '0;
        end else if (csr_we_i) begin
            case (csr_waddr_i)
                `CLINT_CSR_MSTATUS: begin
                    mstatus_q <= csr_wdata_i;
                end
                `CLINT_CSR_MIE: begin
                    mie_q <= csr_wdata_i;
                end
                `CLINT_CSR_MTVEC: begin
                    mtvec_q <= csr_wdata_i;
                end
                `CLINT_CSR_MSCRATCH: begin
                    mscratch_q <= csr_wdata_i;
                end
                `CLINT_CSR_MEPC: begin
                    mepc_q <= csr_wdata_i;
                end
                `CLINT_CSR_MCAUSE: begin
                    mcause_q <= csr_wdata_i;
                end
                `CLINT_CSR_MIP: begin
                    mip_q <= csr_wdata_i;
                end
                // misa, mhartid and unmapped addresses drop the write
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== src/trap_fsm.sv ====
`timescale 1ns/1ps
`include "clint_config.svh"

module trap_fsm import clint_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // request from the decoder
    input  logic                   req_valid_i,
    input  csr_op_e                req_op_i,
    input  logic [11:0]            req_addr_i,
    input  logic [`CLINT_XLEN-1:0] req_operand_i,
    input  logic [`CLINT_XLEN-1:0] req_pc_i,
    output logic                   req_ready_o,

    input  logic                   timer_irq_i,

    // register file side
    output logic                   csr_we_o,
    output logic [11:0]            csr_waddr_o,
    output logic [`CLINT_XLEN-1:0] csr_wdata_o,
    output logic [11:0]            csr_raddr_o,
    input  logic [`CLINT_XLEN-1:0] csr_rdata_i,
    input  logic [`CLINT_XLEN-1:0] mstatus_i,
    input  logic [`CLINT_XLEN-1:0] mepc_i,
    input  logic [`CLINT_XLEN-1:0] mtvec_i,

    // writeback and redirect pulses
    output logic                   wb_valid_o,
    output logic [`CLINT_XLEN-1:0] wb_data_o,
    output logic                   jump_valid_o,
    output logic [`CLINT_XLEN-1:0] jump_pc_o
);

    clint_state_e state_q;
    clint_state_e state_d;

    // latched request
    csr_op_e                op_q;
    logic                   irq_q;
    logic [11:0]            addr_q;
    logic [`CLINT_XLEN-1:0] operand_q;
    logic [`CLINT_XLEN-1:0] pc_q;

    logic                   idle_free;
    logic                   irq_take;
    logic                   req_fire;
    logic                   is_mret;
    logic [`CLINT_XLEN-1:0] cause_val;
    logic [`CLINT_XLEN-1:0] mstatus_trap;
    logic [`CLINT_XLEN-1:0] mstatus_ret;

    // the cycle carrying an output pulse still counts as busy
    assign idle_free   = (state_q == ST_IDLE) && !wb_valid_o && !jump_valid_o;
    assign irq_take    = idle_free && timer_irq_i && mstatus_i[`CLINT_MSTATUS_MIE];
    assign req_ready_o = idle_free && !irq_take;  // interrupt wins over a request
    assign req_fire    = req_valid_i && req_ready_o;

    assign is_mret = !irq_q && (op_q == OP_MRET);

    always_comb begin
        if (irq_q) begin
            cause_val = `CLINT_CAUSE_MTIMER;
        end else if (op_q == OP_EBREAK) begin
            cause_val = `CLINT_CAUSE_EBREAK;
        end else begin
            cause_val = `CLINT_CAUSE_ECALL;
        end
    end

    // mstatus images for trap entry and for mret
    always_comb begin
        mstatus_trap = mstatus_i;
        mstatus_trap[`CLINT_MSTATUS_MPIE] = mstatus_i[`CLINT_MSTATUS_MIE];
        mstatus_trap[`CLINT_MSTATUS_MIE]  = 1'b0;

        mstatus_ret = mstatus_i;
        mstatus_ret[`CLINT_MSTATUS_MIE]  = mstatus_i[`CLINT_MSTATUS_MPIE];
        mstatus_ret[`CLINT_MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (irq_take) begin
                    state_d = ST_CAUSE;
                end else if (req_fire) begin
                    case (req_op_i)
                        OP_CSRRW, OP_CSRRS, OP_CSRRC: state_d = ST_CSR;
                        OP_ECALL, OP_EBREAK:          state_d = ST_CAUSE;
                        OP_MRET:                      state_d = ST_STATUS;
                        default:                      state_d = ST_IDLE;  // OP_NONE
                    endcase
                end
            end
            ST_CSR:    state_d = ST_IDLE;
            ST_CAUSE:  state_d = ST_EPC;
            ST_EPC:    state_d = ST_STATUS;
            ST_STATUS: state_d = ST_JUMP;
            ST_JUMP:   state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // what kind of sequence is running
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q  <= OP_NONE;
            irq_q <= 1'b0;
        end else if (irq_take) begin
            op_q  <= OP_NONE;
            irq_q <= 1'b1;
        end else if (req_fire) begin
            op_q  <= req_op_i;
            irq_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (irq_take) begin
            pc_q <= req_pc_i;  // pc sampled even without valid
        end else if (req_fire) begin
            addr_q    <= req_addr_i;
            operand_q <= req_operand_i;
            pc_q      <= req_pc_i;
        end
    end

    assign csr_raddr_o = addr_q;

    // write issued here lands at the end of the current state
    always_comb begin
        csr_we_o    = 1'b0;
        csr_waddr_o = addr_q;
        csr_wdata_o = operand_q;
        case (state_q)
            ST_CSR: begin
                csr_we_o = 1'b1;
                case (op_q)
                    OP_CSRRS: csr_wdata_o = csr_rdata_i | operand_q;
                    OP_CSRRC: csr_wdata_o = csr_rdata_i & ~operand_q;
                    default:  csr_wdata_o = operand_q;
                endcase
            end
            ST_CAUSE: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = `CLINT_CSR_MCAUSE;
                csr_wdata_o = cause_val;
            end
            ST_EPC: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = `CLINT_CSR_MEPC;
                csr_wdata_o = pc_q;
            end
            ST_STATUS: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = `CLINT_CSR_MSTATUS;
                csr_wdata_o = is_mret ? mstatus_ret : mstatus_trap;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_o   <= 1'b0;
            jump_valid_o <= 1'b0;
        end else begin
            wb_valid_o   <= (state_q == ST_CSR);
            jump_valid_o <= (state_q == ST_JUMP);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_CSR) begin
            wb_data_o <= csr_rdata_i;  // old value goes to rd
        end
        if (state_q == ST_JUMP) begin
            jump_pc_o <= is_mret ? mepc_i : mtvec_i;
        end
    end

endmodule

// ==== src/clint_top.sv ====
`timescale 1ns/1ps

module clint_top import clint_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        req_valid_i,
    input  csr_op_e     req_op_i,
    input  logic [11:0] req_addr_i,
    input  logic [31:0] req_operand_i,
    input  logic [31:0] req_pc_i,
    output logic        req_ready_o,

    input  logic        timer_irq_i,

    output logic        wb_valid_o,
    output logic [31:0] wb_data_o,
    output logic        jump_valid_o,
    output logic [31:0] jump_pc_o
);

    logic        csr_we;
    logic [11:0] csr_waddr;
    logic [31:0] csr_wdata;
    logic [11:0] csr_raddr;
    logic [31:0] csr_rdata;
    logic [31:0] mstatus_q;
    logic [31:0] mepc_q;
    logic [31:0] mtvec_q;

    csr_regfile u_csr_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_we_i    (csr_we),
        .csr_waddr_i (csr_waddr),
        .csr_wdata_i (csr_wdata),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .mstatus_o   (mstatus_q),
        .mepc_o      (mepc_q),
        .mtvec_o     (mtvec_q)
    );

    trap_fsm u_trap_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_operand_i (req_operand_i),
        .req_pc_i      (req_pc_i),
        .req_ready_o   (req_ready_o),
        .timer_irq_i   (timer_irq_i),
        .csr_we_o      (csr_we),
        .csr_waddr_o   (csr_waddr),
        .csr_wdata_o   (csr_wdata),
        .csr_raddr_o   (csr_raddr),
        .csr_rdata_i   (csr_rdata),
        .mstatus_i     (mstatus_q),
        .mepc_i        (mepc_q),
        .mtvec_i       (mtvec_q),
        .wb_valid_o    (wb_valid_o),
        .wb_data_o     (wb_data_o),
        .jump_valid_o  (jump_valid_o),
        .jump_pc_o     (jump_pc_o)
    );

endmodule

// ==== include/tb_clint_table.svh ====
`ifndef TB_CLINT_TABLE_SVH
`define TB_CLINT_TABLE_SVH

// columns: op, csr address, operand, pc, irq, expected kind, expected value
// irq rows raise timer_irq_i and leave the request side idle

localparam int NUM_ROWS = 30;

typedef enum logic [1:0] {
    EXP_NONE,
    EXP_WB,
    EXP_JUMP
} exp_kind_e;

typedef struct packed {
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] operand;
    logic [31:0] pc;
    logic        irq;
    exp_kind_e   kind;
    logic [31:0] value;
} row_t;

row_t rows [NUM_ROWS];

task automatic set_row(input int idx, input csr_op_e op, input logic [11:0] addr,
                       input logic [31:0] operand, input logic [31:0] pc,
                       input logic irq, input exp_kind_e kind, input logic [31:0] value);
    rows[idx].op      = op;
    rows[idx].addr    = addr;
    rows[idx].operand = operand;
    rows[idx].pc      = pc;
    rows[idx].irq     = irq;
    rows[idx].kind    = kind;
    rows[idx].value   = value;
endtask

task automatic load_rows();
    set_row(0,  OP_CSRRW,  `CLINT_CSR_MSCRATCH, 32'h1234, 32'h0, 1'b0, EXP_WB, 32'h0);
    set_row(1,  OP_CSRRW,  `CLINT_CSR_MSCRATCH, 32'h5678, 32'h0, 1'b0, EXP_WB, 32'h1234);
    set_row(2,  OP_CSRRS,  `CLINT_CSR_MSCRATCH, 32'h00F0, 32'h0, 1'b0, EXP_WB, 32'h5678);
    set_row(3,  OP_CSRRC,  `CLINT_CSR_MSCRATCH, 32'h0070, 32'h0, 1'b0, EXP_WB, 32'h56F8);
    set_row(4,  OP_CSRRS,  `CLINT_CSR_MSCRATCH, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h5688);
    set_row(5,  OP_CSRRS,  `CLINT_CSR_MISA, 32'h0, 32'h0, 1'b0, EXP_WB, `CLINT_MISA_VALUE);
    set_row(6,  OP_CSRRS,  `CLINT_CSR_MHARTID, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h0);
    set_row(7,  OP_CSRRW,  `CLINT_CSR_MISA, 32'hFFFF_FFFF, 32'h0, 1'b0, EXP_WB,
            `CLINT_MISA_VALUE);
    set_row(8,  OP_CSRRS,  `CLINT_CSR_MISA, 32'h0, 32'h0, 1'b0, EXP_WB, `CLINT_MISA_VALUE);
    set_row(9,  OP_CSRRW,  12'h7C0, 32'hDEAD_BEEF, 32'h0, 1'b0, EXP_WB, 32'h0);  // unmapped
    set_row(10, OP_CSRRS,  12'h7C0, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h0);
    set_row(11, OP_CSRRW,  `CLINT_CSR_MTVEC, 32'h100, 32'h0, 1'b0, EXP_WB, 32'h0);
    set_row(12, OP_ECALL,  12'h0, 32'h0, 32'h40, 1'b0, EXP_JUMP, 32'h100);
    set_row(13, OP_CSRRS,  `CLINT_CSR_MCAUSE, 32'h0, 32'h0, 1'b0, EXP_WB, `CLINT_CAUSE_ECALL);
    set_row(14, OP_CSRRS,  `CLINT_CSR_MEPC, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h40);
    set_row(15, OP_CSRRS,  `CLINT_CSR_MSTATUS, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h0);
    set_row(16, OP_EBREAK, 12'h0, 32'h0, 32'h44, 1'b0, EXP_JUMP, 32'h100);
    set_row(17, OP_CSRRS,  `CLINT_CSR_MCAUSE, 32'h0, 32'h0, 1'b0, EXP_WB, `CLINT_CAUSE_EBREAK);
    set_row(18, OP_CSRRW,  `CLINT_CSR_MEPC, 32'h80, 32'h0, 1'b0, EXP_WB, 32'h44);
    set_row(19, OP_CSRRW,  `CLINT_CSR_MSTATUS, 32'h80, 32'h0, 1'b0, EXP_WB, 32'h0);  // mpie only
    set_row(20, OP_MRET,   12'h0, 32'h0, 32'h48, 1'b0, EXP_JUMP, 32'h80);
    set_row(21, OP_CSRRS,  `CLINT_CSR_MSTATUS, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h88);
    set_row(22, OP_CSRRC,  `CLINT_CSR_MSTATUS, 32'h8, 32'h0, 1'b0, EXP_WB, 32'h88);
    set_row(23, OP_NONE,   12'h0, 32'h0, 32'h200, 1'b1, EXP_NONE, 32'h0);  // mie off
    set_row(24, OP_CSRRS,  `CLINT_CSR_MSTATUS, 32'h8, 32'h0, 1'b0, EXP_WB, 32'h80);
    set_row(25, OP_NONE,   12'h0, 32'h0, 32'h204, 1'b1, EXP_JUMP, 32'h100);
    set_row(26, OP_CSRRS,  `CLINT_CSR_MCAUSE, 32'h0, 32'h0, 1'b0, EXP_WB, `CLINT_CAUSE_MTIMER);
    set_row(27, OP_CSRRS,  `CLINT_CSR_MEPC, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h204);
    set_row(28, OP_CSRRS,  `CLINT_CSR_MSTATUS, 32'h0, 32'h0, 1'b0, EXP_WB, 32'h80);
    set_row(29, OP_NONE,   12'h0, 32'h0, 32'h0, 1'b0, EXP_NONE, 32'h0);  // accepted, no effect
endtask

`endif

// ==== test/tb_clint.sv ====
`timescale 1ns/1ps
`include "clint_config.svh"

module tb_clint import clint_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int PULSE_WAIT   = 10;
    localparam int READY_WAIT   = 20;

    logic        clk;
    logic        rst_n;
    logic        req_valid_i;
    csr_op_e     req_op_i;
    logic [11:0] req_addr_i;
    logic [31:0] req_operand_i;
    logic [31:0] req_pc_i;
    logic        req_ready_o;
    logic        timer_irq_i;
    logic        wb_valid_o;
    logic [31:0] wb_data_o;
    logic        jump_valid_o;
    logic [31:0] jump_pc_o;

    int pass_count;
    int fail_count;

    `include "tb_clint_table.svh"

    clint_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_operand_i (req_operand_i),
        .req_pc_i      (req_pc_i),
        .req_ready_o   (req_ready_o),
        .timer_irq_i   (timer_irq_i),
        .wb_valid_o    (wb_valid_o),
        .wb_data_o     (wb_data_o),
        .jump_valid_o  (jump_valid_o),
        .jump_pc_o     (jump_pc_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic count_pass(input int idx, input logic [31:0] got);
        $display("row %0d ok: 0x%08h", idx, got);
        pass_count++;
    endtask

    task automatic show_mismatch(input int idx, input logic [31:0] exp, input logic [31:0] got);
        $display("ERROR at time %0d ns: row %0d expected 0x%08h, got 0x%08h",
                 $time, idx, exp, got);
        fail_count++;
    endtask

    task automatic report_problem(input int idx, input string what);
        $display("row %0d: %s", idx, what);
        fail_count++;
    endtask

    // called on a rising edge, returns on the transfer edge
    task automatic send_request(input int idx, output logic ok);
        int waited;
        ok     = 1'b0;
        waited = 0;
        req_op_i      <= rows[idx].op;
        req_addr_i    <= rows[idx].addr;
        req_operand_i <= rows[idx].operand;
        req_pc_i      <= rows[idx].pc;
        req_valid_i   <= 1'b1;
        while (!ok && waited < READY_WAIT) begin
            @(negedge clk);
            if (req_ready_o) begin
                ok = 1'b1;  // next edge transfers
            end
            waited++;
            @(posedge clk);
        end
        req_valid_i <= 1'b0;
    endtask

    // ready stays low while a sequence runs, up to and including its pulse
    task automatic watch_outputs(input logic ready_exp, output logic seen_wb,
                                 output logic seen_jump, output logic [31:0] got,
                                 output logic ready_bad);
        int n;
        seen_wb   = 1'b0;
        seen_jump = 1'b0;
        got       = '0;
        ready_bad = 1'b0;
        n         = 0;
        while (!seen_wb && !seen_jump && n < PULSE_WAIT) begin
            @(negedge clk);
            if (req_ready_o !== ready_exp) begin
                ready_bad = 1'b1;
            end
            if (wb_valid_o) begin
                seen_wb = 1'b1;
                got     = wb_data_o;
            end else if (jump_valid_o) begin
                seen_jump = 1'b1;
                got       = jump_pc_o;
            end
            n++;
        end
    endtask

    task automatic run_row(input int idx);
        logic        accepted;
        logic        seen_wb;
        logic        seen_jump;
        logic        ready_bad;
        logic [31:0] got;
        accepted = 1'b1;
        @(posedge clk);
        if (rows[idx].irq) begin
            req_pc_i    <= rows[idx].pc;
            timer_irq_i <= 1'b1;
        end else begin
            send_request(idx, accepted);
        end
        if (!accepted) begin
            report_problem(idx, $sformatf("request not accepted within %0d cycles", READY_WAIT));
        end else begin
            watch_outputs(rows[idx].kind == EXP_NONE, seen_wb, seen_jump, got, ready_bad);
            case (rows[idx].kind)
                EXP_WB: begin
                    if (!seen_wb) begin
                        report_problem(idx, $sformatf("no writeback seen within %0d cycles",
                                                      PULSE_WAIT));
                    end else if (got !== rows[idx].value) begin
                        show_mismatch(idx, rows[idx].value, got);
                    end else if (ready_bad) begin
                        report_problem(idx, "req_ready_o was high while the unit was busy");
                    end else begin
                        count_pass(idx, got);
                    end
                end
                EXP_JUMP: begin
                    if (!seen_jump) begin
                        report_problem(idx, $sformatf("no jump seen within %0d cycles",
                                                      PULSE_WAIT));
                    end else if (got !== rows[idx].value) begin
                        show_mismatch(idx, rows[idx].value, got);
                    end else if (ready_bad) begin
                        report_problem(idx, "req_ready_o was high while the unit was busy");
                    end else begin
                        count_pass(idx, got);
                    end
                end
                default: begin
                    if (seen_wb || seen_jump) begin
                        report_problem(idx, "an output pulse appeared where none was expected");
                    end else if (ready_bad) begin
                        report_problem(idx, "req_ready_o was low while the unit was idle");
                    end else begin
                        count_pass(idx, got);
                    end
                end
            endcase
        end
        if (rows[idx].irq) begin
            @(posedge clk);
            timer_irq_i <= 1'b0;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        req_valid_i   = 1'b0;
        req_op_i      = OP_NONE;
        req_addr_i    = '0;
        req_operand_i = '0;
        req_pc_i      = '0;
        timer_irq_i   = 1'b0;
        pass_count    = 0;
        fail_count    = 0;
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("summary: %0d rows passed, %0d rows with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, 20 cycles per row
    initial begin
        #(NUM_ROWS * 20 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d ns", NUM_ROWS * 20 * CLK_PERIOD);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
src/clint_pkg.sv
src/csr_regfile.sv
src/trap_fsm.sv
src/clint_top.sv
test/tb_clint.sv
